// ==== Makefile ====
TOP := ex_stage_tb

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f ex_stage.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== ex_stage.f ====
logic/ex_pkg.sv
logic/ex_decode.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_div.sv
logic/ex_stage.sv
tb/ex_stage_assert.sv
tb/ex_stage_tb.sv

// ==== logic/ex_alu.sv ====
`timescale 1ns/1ps

module ex_alu #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    input  ex_pkg::alu_op_e alu_op_i,
    output logic [XLEN-1:0] result_o
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] sra_res;

    assign shamt   = op2_i[SHW-1:0];
    assign sum     = op1_i + op2_i;
    assign diff    = op1_i - op2_i;
    assign lt_s    = $signed(op1_i) < $signed(op2_i);
    assign lt_u    = op1_i < op2_i;
    assign sra_res = $unsigned($signed(op1_i) >>> shamt);  // sign fill

    always_comb begin
        case (alu_op_i)
            ex_pkg::ALU_ADD: begin
                result_o = sum;
            end
            ex_pkg::ALU_SUB: begin
                result_o = diff;
            end
            ex_pkg::ALU_SLL: begin
                result_o = op1_i << shamt;
            end
            ex_pkg::ALU_SLT: begin
                result_o = XLEN'(lt_s);                // 0 or 1
            end
            ex_pkg::ALU_SLTU: begin
                result_o = XLEN'(lt_u);
            end
            ex_pkg::ALU_XOR: begin
                result_o = op1_i ^ op2_i;
            end
            ex_pkg::ALU_SRL: begin
                result_o = op1_i >> shamt;
            end
            ex_pkg::ALU_SRA: begin
                result_o = sra_res;
            end
            ex_pkg::ALU_OR: begin
                result_o = op1_i | op2_i;
            end
            ex_pkg::ALU_AND: begin
                result_o = op1_i & op2_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== logic/ex_branch.sv ====
`timescale 1ns/1ps

module ex_branch #(
    parameter int XLEN = 32
) (
    input  logic [2:0]      funct3_i,
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [XLEN-1:0] jump_base_i,
    input  logic [XLEN-1:0] jump_offset_i,
    input  logic            is_branch_i,
    input  logic            is_jump_i,
    output logic            jump_flag_o,
    output logic [XLEN-1:0] jump_addr_o
);

    logic [XLEN-1:0] target;
    logic            lt_s;
    logic            lt_u;
    logic            cond;

    assign target = jump_base_i + jump_offset_i;       // jalr keeps bit 0
    assign lt_s   = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u   = rs1_i < rs2_i;

    always_comb begin
        case (funct3_i)
            ex_pkg::F3_BEQ:  cond = (rs1_i == rs2_i);
            ex_pkg::F3_BNE:  cond = (rs1_i != rs2_i);
            ex_pkg::F3_BLT:  cond = lt_s;
            ex_pkg::F3_BGE:  cond = !lt_s;
            ex_pkg::F3_BLTU: cond = lt_u;
            ex_pkg::F3_BGEU: cond = !lt_u;
            default:         cond = 1'b0;              // 010/011 are reserved
        endcase
    end

    assign jump_flag_o = is_jump_i || (is_branch_i && cond);
    assign jump_addr_o = jump_flag_o ? target : '0;

endmodule

// ==== logic/ex_decode.sv ====
`timescale 1ns/1ps

module ex_decode #(
    parameter int XLEN = 32
) (
    input  logic [ex_pkg::INST_W-1:0] inst_i,
    input  logic [XLEN-1:0]           inst_addr_i,
    input  logic [XLEN-1:0]           rs1_data_i,
    input  logic [XLEN-1:0]           rs2_data_i,
    output logic [XLEN-1:0]           op1_o,
    output logic [XLEN-1:0]           op2_o,
    output ex_pkg::alu_op_e           alu_op_o,
    output logic [XLEN-1:0]           jump_base_o,
    output logic [XLEN-1:0]           jump_offset_o,
    output logic                      is_branch_o,
    output logic                      is_jump_o,
    output logic                      mem_r_ena_o,
    output logic                      mem_w_ena_o,
    output logic                      reg_w_ena_o,
    output logic                      div_req_o,
    output logic                      div_signed_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            is_muldiv;
    ex_pkg::alu_op_e alu_op_fn;                        // op picked by funct3

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = XLEN'($signed(inst_i[31:20]));
    assign imm_s = XLEN'($signed({inst_i[31:25], inst_i[11:7]}));
    assign imm_b = XLEN'($signed({inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0}));
    assign imm_u = XLEN'($signed({inst_i[31:12], 12'b0}));
    assign imm_j = XLEN'($signed({inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0}));

    assign is_muldiv    = (funct7 == ex_pkg::F7_MULDIV);
    assign div_req_o    = (opcode == ex_pkg::OPC_OP) && is_muldiv &&
                          ((funct3 == ex_pkg::F3_DIV) || (funct3 == ex_pkg::F3_DIVU));
    assign div_signed_o = div_req_o && (funct3 == ex_pkg::F3_DIV);

    always_comb begin
        case (funct3)
            ex_pkg::F3_ADD_SUB: begin
                if ((opcode == ex_pkg::OPC_OP) && inst_i[30]) begin
                    alu_op_fn = ex_pkg::ALU_SUB;       // sub only in the register form
                end else begin
                    alu_op_fn = ex_pkg::ALU_ADD;
                end
            end
            ex_pkg::F3_SLL:  alu_op_fn = ex_pkg::ALU_SLL;
            ex_pkg::F3_SLT:  alu_op_fn = ex_pkg::ALU_SLT;
            ex_pkg::F3_SLTU: alu_op_fn = ex_pkg::ALU_SLTU;
            ex_pkg::F3_XOR:  alu_op_fn = ex_pkg::ALU_XOR;
            ex_pkg::F3_SR: begin
                if (inst_i[30]) begin
                    alu_op_fn = ex_pkg::ALU_SRA;
                end else begin
                    alu_op_fn = ex_pkg::ALU_SRL;
                end
            end
            ex_pkg::F3_OR:   alu_op_fn = ex_pkg::ALU_OR;
            default:         alu_op_fn = ex_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        op1_o         = '0;
        op2_o         = '0;
        alu_op_o      = ex_pkg::ALU_ADD;
        jump_base_o   = '0;
        jump_offset_o = '0;
        is_branch_o   = 1'b0;
        is_jump_o     = 1'b0;
        mem_r_ena_o   = 1'b0;
        mem_w_ena_o   = 1'b0;
        reg_w_ena_o   = 1'b0;
        case (opcode)
            ex_pkg::OPC_OP_IMM: begin
                op1_o       = rs1_data_i;
                op2_o       = imm_i;                   // shamt sits in the low bits
                alu_op_o    = alu_op_fn;
                reg_w_ena_o = 1'b1;
            end
            ex_pkg::OPC_OP: begin
                if (!is_muldiv) begin
                    op1_o       = rs1_data_i;
                    op2_o       = rs2_data_i;
                    alu_op_o    = alu_op_fn;
                    reg_w_ena_o = 1'b1;
                end else begin
                    reg_w_ena_o = div_req_o;           // multiplies are not supported
                end
            end
            ex_pkg::OPC_LOAD: begin
                op1_o       = rs1_data_i;
                op2_o       = imm_i;
                mem_r_ena_o = 1'b1;
                reg_w_ena_o = 1'b1;
            end
            ex_pkg::OPC_STORE: begin
                op1_o       = rs1_data_i;
                op2_o       = imm_s;
                mem_w_ena_o = 1'b1;
            end
            ex_pkg::OPC_BRANCH: begin
                jump_base_o   = inst_addr_i;
                jump_offset_o = imm_b;
                is_branch_o   = 1'b1;
            end
            ex_pkg::OPC_JAL: begin
                op1_o         = inst_addr_i;           // link = pc + 4
                op2_o         = XLEN'(4);
                jump_base_o   = inst_addr_i;
                jump_offset_o = imm_j;
                is_jump_o     = 1'b1;
                reg_w_ena_o   = 1'b1;
            end
            ex_pkg::OPC_JALR: begin
                op1_o         = inst_addr_i;
                op2_o         = XLEN'(4);
                jump_base_o   = rs1_data_i;
                jump_offset_o = imm_i;
                is_jump_o     = 1'b1;
                reg_w_ena_o   = 1'b1;
            end
            ex_pkg::OPC_LUI: begin
                op1_o       = imm_u;
                reg_w_ena_o = 1'b1;
            end
            ex_pkg::OPC_AUIPC: begin
                op1_o       = inst_addr_i;
                op2_o       = imm_u;
                reg_w_ena_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== logic/ex_div.sv ====
`timescale 1ns/1ps

module ex_div #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            req_i,
    input  logic            signed_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    output logic            busy_o,
    output logic            done_o,
    output logic [XLEN-1:0] quotient_o
);

    localparam int CW = $clog2(XLEN);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } state_e;

    state_e          state;
    logic [CW-1:0]   cnt;
    logic [XLEN-1:0] quo;                              // dividend shifts out, quotient in
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] dsr;
    logic            neg;
    logic            div_zero;

    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;
    logic [XLEN:0]   shifted;
    logic [XLEN:0]   trial;

    assign a_mag = (signed_i && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
    assign b_mag = (signed_i && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;

    // one restoring step
    assign shifted = {rem, quo[XLEN-1]};
    assign trial   = shifted - {1'b0, dsr};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_i) begin
                        state <= S_RUN;
                        cnt   <= CW'(XLEN - 1);
                    end
                end
                S_RUN: begin
                    if (cnt == '0) begin
                        state <= S_DONE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;                   // a held req restarts from idle
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_i) begin
            quo      <= a_mag;
            rem      <= '0;
            dsr      <= b_mag;
            neg      <= signed_i && (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]);
            div_zero <= (divisor_i == '0);
        end else if (state == S_RUN) begin
            if (!trial[XLEN]) begin
                rem <= trial[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end else begin
                rem <= shifted[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end
    end

    assign busy_o     = (state == S_RUN);
    assign done_o     = (state == S_DONE);
    assign quotient_o = div_zero ? '1 : (neg ? -quo : quo);

endmodule

// ==== logic/ex_pkg.sv ====
package ex_pkg;

    localparam int INST_W = 32;

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // alu funct3, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // M extension, only the divides are kept
    localparam logic [2:0] F3_DIV  = 3'b100;
    localparam logic [2:0] F3_DIVU = 3'b101;

    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

// ==== logic/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage #(
    parameter int XLEN = 32
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic [ex_pkg::INST_W-1:0] inst_i,
    input  logic [XLEN-1:0]           inst_addr_i,
    input  logic [XLEN-1:0]           rs1_data_i,
    input  logic [XLEN-1:0]           rs2_data_i,
    output logic                      reg_w_ena_o,
    output logic [4:0]                reg_w_addr_o,
    output logic [XLEN-1:0]           reg_w_data_o,
    output logic                      mem_r_ena_o,
    output logic [XLEN-1:0]           mem_r_addr_o,
    output logic                      mem_w_ena_o,
    output logic [XLEN-1:0]           mem_w_addr_o,
    output logic [XLEN-1:0]           mem_w_data_o,
    output logic                      jump_flag_o,
    output logic [XLEN-1:0]           jump_addr_o,
    output logic                      div_hold_o
);

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    ex_pkg::alu_op_e alu_op;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] jump_base;
    logic [XLEN-1:0] jump_offset;
    logic            is_branch;
    logic            is_jump;
    logic            dec_reg_w_ena;
    logic            div_req;
    logic            div_signed;
    logic            div_busy;
    logic            div_done;
    logic [XLEN-1:0] div_quotient;

    ex_decode #(.XLEN(XLEN)) u_decode (
        .inst_i        (inst_i),
        .inst_addr_i   (inst_addr_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .op1_o         (op1),
        .op2_o         (op2),
        .alu_op_o      (alu_op),
        .jump_base_o   (jump_base),
        .jump_offset_o (jump_offset),
        .is_branch_o   (is_branch),
        .is_jump_o     (is_jump),
        .mem_r_ena_o   (mem_r_ena_o),
        .mem_w_ena_o   (mem_w_ena_o),
        .reg_w_ena_o   (dec_reg_w_ena),
        .div_req_o     (div_req),
        .div_signed_o  (div_signed)
    );

    ex_alu #(.XLEN(XLEN)) u_alu (
        .op1_i    (op1),
        .op2_i    (op2),
        .alu_op_i (alu_op),
        .result_o (alu_result)
    );

    ex_branch #(.XLEN(XLEN)) u_branch (
        .funct3_i      (inst_i[14:12]),
        .rs1_i         (rs1_data_i),
        .rs2_i         (rs2_data_i),
        .jump_base_i   (jump_base),
        .jump_offset_i (jump_offset),
        .is_branch_i   (is_branch),
        .is_jump_i     (is_jump),
        .jump_flag_o   (jump_flag_o),
        .jump_addr_o   (jump_addr_o)
    );

    ex_div #(.XLEN(XLEN)) u_div (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_i      (div_req),
        .signed_i   (div_signed),
        .dividend_i (rs1_data_i),
        .divisor_i  (rs2_data_i),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .quotient_o (div_quotient)
    );

    assign div_hold_o   = div_req && !div_done;        // stall upstream until done
    assign reg_w_ena_o  = dec_reg_w_ena && !div_hold_o;
    assign reg_w_addr_o = inst_i[11:7];

    always_comb begin
        if (div_req) begin
            reg_w_data_o = div_quotient;
        end else if (dec_reg_w_ena && !mem_r_ena_o) begin
            reg_w_data_o = alu_result;
        end else begin
            reg_w_data_o = '0;                         // load data comes from mem stage
        end
    end

    assign mem_r_addr_o = mem_r_ena_o ? alu_result : '0;
    assign mem_w_addr_o = mem_w_ena_o ? alu_result : '0;
    assign mem_w_data_o = mem_w_ena_o ? rs2_data_i : '0;

endmodule

// ==== tb/ex_stage_assert.sv ====
`timescale 1ns/1ps

module ex_stage_assert #(
    parameter int XLEN = 32
) (
    input logic                      clk,
    input logic                      rst_n_i,
    input logic [ex_pkg::INST_W-1:0] inst_i,
    input logic                      div_busy_i,
    input logic                      div_done_i,
    input logic                      div_hold_i,
    input logic                      jump_flag_i,
    input logic                      mem_w_ena_i,
    input logic                      reg_w_ena_i
);

    logic is_div;
    int   hold_len;                                    // cycles of the current hold

    assign is_div = (inst_i[6:0] == ex_pkg::OPC_OP) && (inst_i[31:25] == ex_pkg::F7_MULDIV) &&
                    ((inst_i[14:12] == ex_pkg::F3_DIV) || (inst_i[14:12] == ex_pkg::F3_DIVU));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_len <= 0;
        end else if (div_hold_i) begin
            hold_len <= hold_len + 1;
        end else begin
            hold_len <= 0;
        end
    end

    busy_only_for_div: assert property (@(posedge clk) disable iff (!rst_n_i)
        div_busy_i |-> is_div)
        else $error("divider running without a divide instruction");

    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        div_done_i |=> !div_done_i)
        else $error("divider done stayed high for more than one cycle");

    no_jump_with_store: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(jump_flag_i && mem_w_ena_i))
        else $error("jump_flag_o and mem_w_ena_o high together");

    write_after_full_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(div_hold_i) |-> (hold_len == XLEN + 1) && div_done_i && reg_w_ena_i)
        else $error("divide result not written right after XLEN+1 hold cycles");

endmodule

// ==== tb/ex_stage_tb.sv ====
`timescale 1ns/1ps

module ex_stage_tb;

    localparam int          XLEN = 32;
    localparam logic [31:0] PC0  = 32'h0000_1000;

    // destination registers used by the encoders
    localparam logic [4:0] RD_R = 5'd3;
    localparam logic [4:0] RD_I = 5'd4;
    localparam logic [4:0] RD_U = 5'd7;
    localparam logic [4:0] RD_J = 5'd1;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        w_ena;
        logic [4:0]  rd;
        logic [31:0] w_data;
        logic        j_flag;
        logic [31:0] j_addr;
        logic        r_ena;
        logic [31:0] r_addr;
        logic        m_ena;
        logic [31:0] m_addr;
        logic [31:0] m_data;
        logic        is_div;
    } vec_t;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic        reg_w_ena_o;
    logic [4:0]  reg_w_addr_o;
    logic [31:0] reg_w_data_o;
    logic        mem_r_ena_o;
    logic [31:0] mem_r_addr_o;
    logic        mem_w_ena_o;
    logic [31:0] mem_w_addr_o;
    logic [31:0] mem_w_data_o;
    logic        jump_flag_o;
    logic [31:0] jump_addr_o;
    logic        div_hold_o;

    vec_t  tbl[$];
    string names[$];
    int    cycles = 0;
    int    limit;

    ex_stage #(.XLEN(XLEN)) DUT (.*);

    bind ex_stage ex_stage_assert #(.XLEN(XLEN)) u_assert (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .div_busy_i  (div_busy),
        .div_done_i  (div_done),
        .div_hold_i  (div_hold_o),
        .jump_flag_i (jump_flag_o),
        .mem_w_ena_i (mem_w_ena_o),
        .reg_w_ena_i (reg_w_ena_o)
    );

    // fixed registers: rs1 = x1, rs2 = x2
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, RD_R, ex_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {imm, 5'd1, f3, RD_I, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, 3'b010, imm[4:0], ex_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], ex_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [6:0] opc);
        return {imm, RD_U, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], RD_J, ex_pkg::OPC_JAL};
    endfunction

    function automatic vec_t blank(input logic [31:0] inst, pc, a, b);
        vec_t v;
        v      = '0;
        v.inst = inst;
        v.pc   = pc;
        v.rs1  = a;
        v.rs2  = b;
        case (inst[6:0])
            ex_pkg::OPC_OP:                     v.rd = RD_R;
            ex_pkg::OPC_JAL:                    v.rd = RD_J;
            ex_pkg::OPC_LUI, ex_pkg::OPC_AUIPC: v.rd = RD_U;
            default:                            v.rd = RD_I;
        endcase
        return v;
    endfunction

    task automatic push(input string name, input vec_t v);
        names.push_back(name);
        tbl.push_back(v);
    endtask

    task automatic add_write(input string name, input logic [31:0] inst, a, b, res);
        vec_t v;
        v        = blank(inst, PC0, a, b);
        v.w_ena  = 1'b1;
        v.w_data = res;
        push(name, v);
    endtask

    task automatic add_branch(input string name, input logic [31:0] inst, a, b,
                              input logic taken, input logic [31:0] target);
        vec_t v;
        v        = blank(inst, PC0, a, b);
        v.j_flag = taken;
        v.j_addr = taken ? target : '0;
        push(name, v);
    endtask

    task automatic add_link(input string name, input logic [31:0] inst, pc, a, res,
                            input logic jump, input logic [31:0] target);
        vec_t v;
        v        = blank(inst, pc, a, 32'h0);
        v.w_ena  = 1'b1;
        v.w_data = res;
        v.j_flag = jump;
        v.j_addr = jump ? target : '0;
        push(name, v);
    endtask

    task automatic add_mem(input string name, input logic [31:0] inst, a, b,
                           input logic store, input logic [31:0] addr);
        vec_t v;
        v = blank(inst, PC0, a, b);
        if (store) begin
            v.m_ena  = 1'b1;
            v.m_addr = addr;
            v.m_data = b;
        end else begin
            v.r_ena  = 1'b1;
            v.r_addr = addr;
            v.w_ena  = 1'b1;                           // load data joins later
        end
        push(name, v);
    endtask

    task automatic add_div(input string name, input logic [31:0] inst, a, b, q);
        vec_t v;
        v        = blank(inst, PC0, a, b);
        v.w_ena  = 1'b1;
        v.w_data = q;
        v.is_div = 1'b1;
        push(name, v);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s: %s expected %h, actual %h", name, what, exp, act);
            $display("Simulation failed");
            $fatal(1, "%s: %s mismatch", name, what);
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp, act);
        assert (act === exp) else begin
            $display("[FAIL] %s: %s expected %b, actual %b", name, what, exp, act);
            $display("Simulation failed");
            $fatal(1, "%s: %s mismatch", name, what);
        end
    endtask

    task automatic check_outputs(input int i);
        vec_t v;
        v = tbl[i];
        check_flag(names[i], "reg_w_ena_o", v.w_ena, reg_w_ena_o);
        if (v.w_ena) begin
            check_value(names[i], "reg_w_addr_o", {27'b0, v.rd}, {27'b0, reg_w_addr_o});
            check_value(names[i], "reg_w_data_o", v.w_data, reg_w_data_o);
        end
        check_flag(names[i], "jump_flag_o", v.j_flag, jump_flag_o);
        check_value(names[i], "jump_addr_o", v.j_addr, jump_addr_o);
        check_flag(names[i], "mem_r_ena_o", v.r_ena, mem_r_ena_o);
        check_value(names[i], "mem_r_addr_o", v.r_addr, mem_r_addr_o);
        check_flag(names[i], "mem_w_ena_o", v.m_ena, mem_w_ena_o);
        check_value(names[i], "mem_w_addr_o", v.m_addr, mem_w_addr_o);
        check_value(names[i], "mem_w_data_o", v.m_data, mem_w_data_o);
        check_flag(names[i], "div_hold_o", 1'b0, div_hold_o);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rc;
        logic [31:0] fill;
        int          hold_cycles;
        inst_i      = '0;
        inst_addr_i = '0;
        rs1_data_i  = '0;
        rs2_data_i  = '0;
        rst_n_i     = 1'b0;
        void'($urandom(32'hca4120a7));
        ra   = $urandom();
        rb   = $urandom();
        rc   = {16'b0, rb[15:0]} | 32'h1;              // nonzero divisor
        fill = ra[31] ? ~(32'hffff_ffff >> rb[4:0]) : 32'h0;

        push("nop after reset", blank(32'h0, PC0, 32'h0, 32'h0));
        add_write("add", r_type(7'h00, ex_pkg::F3_ADD_SUB), 32'h1234_5678, 32'h0f0f_0f0f,
                  32'h2143_6587);
        add_write("sub", r_type(7'h20, ex_pkg::F3_ADD_SUB), 32'd5, 32'd7, 32'hffff_fffe);
        add_write("sll", r_type(7'h00, ex_pkg::F3_SLL), 32'h1, 32'h21, 32'h2);
        add_write("slt mixed", r_type(7'h00, ex_pkg::F3_SLT), 32'hffff_fffb, 32'd3, 32'd1);
        add_write("sltu mixed", r_type(7'h00, ex_pkg::F3_SLTU), 32'hffff_fffb, 32'd3, 32'd0);
        add_write("xor", r_type(7'h00, ex_pkg::F3_XOR), 32'hf0f0_f0f0, 32'hff00_ff00,
                  32'h0ff0_0ff0);
        add_write("srl", r_type(7'h00, ex_pkg::F3_SR), 32'h8000_0010, 32'd4, 32'h0800_0001);
        add_write("sra", r_type(7'h20, ex_pkg::F3_SR), 32'h8000_0010, 32'd4, 32'hf800_0001);
        add_write("or", r_type(7'h00, ex_pkg::F3_OR), 32'hf0f0_0000, 32'h0f0f, 32'hf0f0_0f0f);
        add_write("and", r_type(7'h00, ex_pkg::F3_AND), 32'hf0f0_f0f0, 32'hff00_ff00,
                  32'hf000_f000);
        add_write("addi negative", i_type(12'hff0, ex_pkg::F3_ADD_SUB, ex_pkg::OPC_OP_IMM),
                  32'h100, 32'hdead_beef, 32'hf0);
        add_write("srai", i_type(12'h408, ex_pkg::F3_SR, ex_pkg::OPC_OP_IMM),
                  32'h8765_4321, 32'h0, 32'hff87_6543);
        add_write("slli", i_type(12'h004, ex_pkg::F3_SLL, ex_pkg::OPC_OP_IMM),
                  32'hff, 32'h0, 32'hff0);
        add_write("slti", i_type(12'hfff, ex_pkg::F3_SLT, ex_pkg::OPC_OP_IMM),
                  32'hffff_fffe, 32'h0, 32'd1);
        add_write("sltiu", i_type(12'hfff, ex_pkg::F3_SLTU, ex_pkg::OPC_OP_IMM),
                  32'd5, 32'h0, 32'd1);
        add_write("ori", i_type(12'h800, ex_pkg::F3_OR, ex_pkg::OPC_OP_IMM),
                  32'h12, 32'h0, 32'hffff_f812);
        add_write("random add", r_type(7'h00, ex_pkg::F3_ADD_SUB), ra, rb, ra + rb);
        add_write("random sub", r_type(7'h20, ex_pkg::F3_ADD_SUB), ra, rb, ra - rb);
        add_write("random sra", r_type(7'h20, ex_pkg::F3_SR), ra, rb, (ra >> rb[4:0]) | fill);
        add_write("random slt", r_type(7'h00, ex_pkg::F3_SLT), ra, rb,
                  {31'b0, $signed(ra) < $signed(rb)});
        add_write("random sltu", r_type(7'h00, ex_pkg::F3_SLTU), ra, rb, {31'b0, ra < rb});

        add_branch("beq taken", b_type(13'd16, ex_pkg::F3_BEQ), 32'h55, 32'h55, 1'b1, 32'h1010);
        add_branch("beq not", b_type(13'h1fe0, ex_pkg::F3_BEQ), 32'h55, 32'h56, 1'b0, 32'h0);
        add_branch("bne taken", b_type(13'h1fe0, ex_pkg::F3_BNE), 32'h1, 32'h2, 1'b1, 32'hfe0);
        add_branch("bne not", b_type(13'd16, ex_pkg::F3_BNE), 32'h7, 32'h7, 1'b0, 32'h0);
        add_branch("blt taken", b_type(13'h0800, ex_pkg::F3_BLT), 32'hffff_ffff, 32'h1, 1'b1,
                   32'h1800);
        add_branch("blt not", b_type(13'h0800, ex_pkg::F3_BLT), 32'h1, 32'hffff_ffff, 1'b0, 32'h0);
        add_branch("bge taken", b_type(13'h1ffc, ex_pkg::F3_BGE), 32'h1, 32'hffff_ffff, 1'b1,
                   32'hffc);
        add_branch("bge not", b_type(13'h1ffc, ex_pkg::F3_BGE), 32'hffff_ffff, 32'h1, 1'b0, 32'h0);
        add_branch("bltu taken", b_type(13'd8, ex_pkg::F3_BLTU), 32'h1, 32'hffff_ffff, 1'b1,
                   32'h1008);
        add_branch("bltu not", b_type(13'd8, ex_pkg::F3_BLTU), 32'hffff_ffff, 32'h1, 1'b0, 32'h0);
        add_branch("bgeu taken", b_type(13'h1800, ex_pkg::F3_BGEU), 32'hffff_ffff, 32'h1, 1'b1,
                   32'h800);
        add_branch("bgeu not", b_type(13'h1800, ex_pkg::F3_BGEU), 32'h1, 32'hffff_ffff, 1'b0,
                   32'h0);

        add_link("jal forward", j_type(21'h100), 32'h2000, 32'h0, 32'h2004, 1'b1, 32'h2100);
        add_link("jal back", j_type(21'h1ffff8), 32'h2000, 32'h0, 32'h2004, 1'b1, 32'h1ff8);
        add_link("jalr odd base", i_type(12'h004, 3'b000, ex_pkg::OPC_JALR), 32'h2000,
                 32'h3001, 32'h2004, 1'b1, 32'h3005);
        add_link("jalr negative", i_type(12'hff0, 3'b000, ex_pkg::OPC_JALR), 32'h2000,
                 32'h3000, 32'h2004, 1'b1, 32'h2ff0);
        add_link("lui", u_type(20'habcde, ex_pkg::OPC_LUI), 32'h2000, 32'h1234,
                 32'habcd_e000, 1'b0, 32'h0);
        add_link("auipc", u_type(20'h00001, ex_pkg::OPC_AUIPC), 32'h2000, 32'h0,
                 32'h3000, 1'b0, 32'h0);
        add_link("auipc negative", u_type(20'hfffff, ex_pkg::OPC_AUIPC), 32'h2000, 32'h0,
                 32'h1000, 1'b0, 32'h0);

        add_mem("lw", i_type(12'h010, 3'b010, ex_pkg::OPC_LOAD), 32'h8000, 32'h1111,
                1'b0, 32'h8010);
        add_mem("sw", s_type(12'hffc), 32'h8000, 32'hcafe_f00d, 1'b1, 32'h7ffc);
        push("unknown opcode", blank(32'hffff_ffff, PC0, 32'h1, 32'h2));

        add_div("div negative", r_type(7'h01, ex_pkg::F3_DIV), 32'hffff_fff9, 32'd2,
                32'hffff_fffd);
        add_div("div negative divisor", r_type(7'h01, ex_pkg::F3_DIV), 32'd100,
                32'hffff_fff9, 32'hffff_fff2);
        add_div("divu", r_type(7'h01, ex_pkg::F3_DIVU), 32'hffff_fff0, 32'd16, 32'h0fff_ffff);
        add_div("div by zero", r_type(7'h01, ex_pkg::F3_DIV), 32'd5, 32'd0, 32'hffff_ffff);
        add_div("divu by zero", r_type(7'h01, ex_pkg::F3_DIVU), 32'd5, 32'd0, 32'hffff_ffff);
        add_div("div min by -1", r_type(7'h01, ex_pkg::F3_DIV), 32'h8000_0000,
                32'hffff_ffff, 32'h8000_0000);
        add_div("random divu", r_type(7'h01, ex_pkg::F3_DIVU), ra, rc, ra / rc);

        limit = 40 + tbl.size() * (XLEN + 4);
        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;

        for (int i = 0; i < tbl.size(); i++) begin
            @(negedge clk);
            inst_i      = tbl[i].inst;
            inst_addr_i = tbl[i].pc;
            rs1_data_i  = tbl[i].rs1;
            rs2_data_i  = tbl[i].rs2;
            if (tbl[i].is_div) begin
                hold_cycles = 0;
                #1;                                    // let the drive settle
                while (div_hold_o) begin
                    hold_cycles++;
                    @(negedge clk);
                end
                check_value(names[i], "hold cycles", XLEN + 1, hold_cycles);
            end else begin
                @(negedge clk);
            end
            check_outputs(i);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
